// File: compile.f
src/fpu_pkg.sv
src/fpu_lane_if.sv
src/fpu_elastic_buf.sv
src/fpu_ncp_lane.sv
src/fpu_ncp_ctrl.sv
src/fpu_ncp.sv
verif/fpu_ncp_chk.sv
verif/fpu_ncp_tb.sv

// File: verif/fpu_ncp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ncp_tb;
    import fpu_pkg::*;

    localparam int NUM_LANES = 4;
    localparam int TAG_W     = 6;
    // About 90 requests and a 100-cycle stall phase
    localparam int MAX_CYCLES = 2000;

    typedef struct packed {
        logic [NUM_LANES-1:0][XLEN-1:0] res;
        logic                           hf;
        logic [4:0]                     ff;
        logic [TAG_W-1:0]               tag;
    } exp_t;

    logic                           clk, arst_n_i, valid_i, ready_i;
    logic                           ready_o, valid_o, has_fflags_o;
    logic [NUM_LANES-1:0]           mask_i;
    logic [TAG_W-1:0]               tag_i, tag_o, next_tag;
    fpu_op_e                        op_type_i;
    logic [2:0]                     frm_i;
    logic [NUM_LANES-1:0][XLEN-1:0] dataa_i, datab_i, result_o;
    fflags_t                        fflags_o;
    exp_t                           exp_q[$];
    exp_t                           exp_head;
    int                             errors, checks, cycles;

    fpu_ncp #(.NUM_LANES(NUM_LANES), .TAG_WIDTH(TAG_W)) i_fpu_ncp (
        .clk(clk), .arst_n_i(arst_n_i), .valid_i(valid_i), .ready_o(ready_o),
        .mask_i(mask_i), .tag_i(tag_i), .op_type_i(op_type_i), .frm_i(frm_i),
        .dataa_i(dataa_i), .datab_i(datab_i), .result_o(result_o),
        .has_fflags_o(has_fflags_o), .fflags_o(fflags_o), .tag_o(tag_o),
        .valid_o(valid_o), .ready_i(ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic is_nan(input logic [31:0] x);
        is_nan = (x[30:23] == 8'hff) && (x[22:0] != 0);
    endfunction

    function automatic logic is_snan(input logic [31:0] x);
        is_snan = is_nan(x) && !x[22];
    endfunction

    // Sign-magnitude to two's complement, both zeros map to 0
    function automatic logic signed [32:0] order_key(input logic [31:0] x);
        order_key = x[31] ? -$signed({2'b00, x[30:0]}) : $signed({2'b00, x[30:0]});
    endfunction

    function automatic int class_index(input logic [31:0] x);
        if (is_nan(x))
            class_index = x[22] ? 9 : 8;
        else if (x[30:23] == 8'hff)
            class_index = x[31] ? 0 : 7;
        else if (x[30:23] != 0)
            class_index = x[31] ? 1 : 6;
        else if (x[22:0] != 0)
            class_index = x[31] ? 2 : 5;
        else
            class_index = x[31] ? 3 : 4;
    endfunction

    // Returns {nv, result} for one active lane
    function automatic logic [32:0] lane_ref(input fpu_op_e op, input logic [2:0] frm,
                                             input logic [31:0] a, input logic [31:0] b);
        logic [31:0]        r;
        logic               nv;
        logic signed [32:0] ka, kb;
        r  = 32'd0;
        nv = 1'b0;
        ka = order_key(a);
        kb = order_key(b);
        if (op == FPU_CMP) begin
            if (frm <= 3'd2 && !is_nan(a) && !is_nan(b))
                r[0] = (frm == 3'd0) ? (ka <= kb) : (frm == 3'd1) ? (ka < kb) : (ka == kb);
            if (frm == 3'd0 || frm == 3'd1)
                nv = is_nan(a) || is_nan(b);
            else if (frm == 3'd2)
                nv = is_snan(a) || is_snan(b);
        end else begin
            case (frm)
                3'd0:       r = {b[31], a[30:0]};
                3'd1:       r = {!b[31], a[30:0]};
                3'd2:       r = {a[31] ^ b[31], a[30:0]};
                3'd3:       r = 32'd1 << class_index(a);
                3'd4, 3'd5: r = a;
                default: begin
                    nv = is_snan(a) || is_snan(b);
                    if (is_nan(a) && is_nan(b))
                        r = CANON_NAN;
                    else if (is_nan(a))
                        r = b;
                    else if (is_nan(b))
                        r = a;
                    else if (ka == kb)
                        r = (a[31] == (frm == 3'd6)) ? a : b;  // -0 is the smaller zero
                    else
                        r = ((ka < kb) == (frm == 3'd6)) ? a : b;
                end
            endcase
        end
        lane_ref = {nv, r};
    endfunction

    function automatic exp_t build_exp(input logic [NUM_LANES-1:0] mask,
                                       input logic [TAG_W-1:0] tag, input fpu_op_e op,
                                       input logic [2:0] frm,
                                       input logic [NUM_LANES-1:0][XLEN-1:0] a,
                                       input logic [NUM_LANES-1:0][XLEN-1:0] b);
        exp_t        e;
        logic [32:0] lr;
        logic        any_nv;
        any_nv = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            lr       = lane_ref(op, frm, a[i], b[i]);
            e.res[i] = mask[i] ? lr[31:0] : 32'd0;
            any_nv   = any_nv | (mask[i] & lr[32]);
        end
        e.hf  = (op == FPU_CMP) || (frm >= 3'd6);
        e.ff  = {any_nv & e.hf, 4'b0000};
        e.tag = tag;
        build_exp = e;
    endfunction

    task automatic check_field(input string name, input logic [127:0] exp,
                               input logic [127:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp, got);
        end
    endtask

    // Expected response recorded at the accepting edge
    always @(posedge clk) begin
        if (arst_n_i && valid_i && ready_o)
            exp_q.push_back(build_exp(mask_i, tag_i, op_type_i, frm_i, dataa_i, datab_i));
    end

    always @(posedge clk) begin
        if (arst_n_i && valid_o && ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Response at time %0t arrived with no request pending", $time);
            end else begin
                exp_head = exp_q.pop_front();
                check_field("result_o", exp_head.res, result_o);
                check_field("has_fflags_o", exp_head.hf, has_fflags_o);
                check_field("fflags_o", exp_head.ff, fflags_o);
                check_field("tag_o", exp_head.tag, tag_o);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [NUM_LANES-1:0][XLEN-1:0] rand_vec();
        for (int i = 0; i < NUM_LANES; i++)
            rand_vec[i] = $urandom;
    endfunction

    function automatic logic [31:0] class_value(input int idx);
        case (idx)
            0:       class_value = 32'hff80_0000;  // -inf
            1:       class_value = 32'hbf80_0000;
            2:       class_value = 32'h8000_0001;
            3:       class_value = 32'h8000_0000;
            4:       class_value = 32'h0000_0000;
            5:       class_value = 32'h0000_0001;
            6:       class_value = 32'h3f80_0000;
            7:       class_value = 32'h7f80_0000;
            8:       class_value = 32'h7f80_0001;  // sNaN
            default: class_value = 32'h7fc0_0000;
        endcase
    endfunction

    // Operand pairs {a, b} for min/max and compare
    function automatic logic [63:0] pair_value(input int idx);
        case (idx)
            0:       pair_value = {32'h3f80_0000, 32'h4000_0000};  // 1 vs 2
            1:       pair_value = {32'hc040_0000, 32'h3f80_0000};  // -3 vs 1
            2:       pair_value = {32'h8000_0000, 32'h0000_0000};
            3:       pair_value = {32'h0000_0000, 32'h8000_0000};
            4:       pair_value = {32'h7fc0_0000, 32'h3f80_0000};  // Quiet NaN in a
            5:       pair_value = {32'h3f80_0000, 32'h7f80_0001};
            6:       pair_value = {32'h7fc0_0000, 32'hffc0_0000};  // Two NaNs
            7:       pair_value = {32'h7fa0_0000, 32'h4000_0000};
            8:       pair_value = {32'h3f80_0000, 32'h3f80_0000};
            9:       pair_value = {32'hbf80_0000, 32'hc000_0000};
            10:      pair_value = {32'h7f80_0000, 32'h7f80_0000};
            default: pair_value = {32'h0000_0001, 32'h8000_0001};
        endcase
    endfunction

    // Called right after a rising edge, returns at the accepting edge
    task automatic send_req(input logic [NUM_LANES-1:0] mask, input fpu_op_e op,
                            input logic [2:0] frm,
                            input logic [NUM_LANES-1:0][XLEN-1:0] a,
                            input logic [NUM_LANES-1:0][XLEN-1:0] b);
        valid_i   <= 1'b1;
        mask_i    <= mask;
        tag_i     <= next_tag;
        op_type_i <= op;
        frm_i     <= frm;
        dataa_i   <= a;
        datab_i   <= b;
        next_tag  = next_tag + 1'b1;
        do @(posedge clk); while (!ready_o);
        valid_i <= 1'b0;
    endtask

    task automatic run_pairs(input fpu_op_e op, input logic [2:0] frm);
        logic [NUM_LANES-1:0][XLEN-1:0] a, b;
        logic [63:0]                    p;
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                p    = pair_value(r * NUM_LANES + i);
                a[i] = p[63:32];
                b[i] = p[31:0];
            end
            send_req('1, op, frm, a, b);
        end
    endtask

    // Inactive lanes carry a signaling NaN that must not raise nv
    task automatic masked_min(input logic [NUM_LANES-1:0] mask);
        logic [NUM_LANES-1:0][XLEN-1:0] a;
        a = rand_vec();
        for (int i = 0; i < NUM_LANES; i++)
            if (!mask[i])
                a[i] = 32'h7f80_0001;
        send_req(mask, FPU_MISC, 3'd6, a, rand_vec());
    endtask

    task automatic test_sgnj_move();
        for (int k = 0; k < 6; k++)
            if (k != 3)
                repeat (3) send_req('1, FPU_MISC, k[2:0], rand_vec(), rand_vec());
    endtask

    task automatic test_classify();
        logic [NUM_LANES-1:0][XLEN-1:0] a;
        for (int k = 0; k < 10; k++) begin
            for (int i = 0; i < NUM_LANES; i++)
                a[i] = class_value((k + i) % 10);
            send_req('1, FPU_MISC, 3'd3, a, rand_vec());
        end
    endtask

    task automatic test_minmax();
        run_pairs(FPU_MISC, 3'd6);
        run_pairs(FPU_MISC, 3'd7);
    endtask

    task automatic test_compare();
        run_pairs(FPU_CMP, 3'd0);  // FLE
        run_pairs(FPU_CMP, 3'd1);
        run_pairs(FPU_CMP, 3'd2);
        run_pairs(FPU_CMP, 3'd5);  // Null compare
    endtask

    task automatic test_mask_tag();
        masked_min(4'b0101);
        masked_min(4'b1010);
        masked_min(4'b0001);
        masked_min(4'b0000);
        masked_min(4'b1110);
    endtask

    task automatic test_backpressure();
        fork
            repeat (40)
                send_req(4'($urandom), ($urandom % 2) ? FPU_MISC : FPU_CMP, 3'($urandom),
                         rand_vec(), rand_vec());
            begin
                repeat (100) begin
                    @(posedge clk);
                    ready_i <= 1'($urandom);
                end
                ready_i <= 1'b1;
            end
        join
    endtask

    initial begin
        void'($urandom(16));
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        next_tag  = '0;
        arst_n_i  = 1'b0;
        valid_i   = 1'b0;
        ready_i   = 1'b1;
        mask_i    = '0;
        tag_i     = '0;
        op_type_i = FPU_MISC;
        frm_i     = 3'd0;
        dataa_i   = '0;
        datab_i   = '0;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
            errors++;
            $display("Handshake outputs not idle after reset");
        end
        test_sgnj_move();
        test_classify();
        test_minmax();
        test_compare();
        test_mask_tag();
        test_backpressure();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fpu_ncp_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ncp_chk #(
    parameter int NUM_LANES = 4,
    parameter int TAG_WIDTH = 6
) (
    input wire                                    clk,
    input wire                                    arst_n_i,
    input wire                                    valid_i,
    input wire                                    ready_i,
    input wire [NUM_LANES-1:0][fpu_pkg::XLEN-1:0] result_i,
    input wire                                    has_fflags_i,
    input var fpu_pkg::fflags_t                   fflags_i,
    input wire [TAG_WIDTH-1:0]                    tag_i
);
    import fpu_pkg::*;

    // A stalled response must hold until taken
    a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        (valid_i && !ready_i) |=> (valid_i && $stable(result_i) && $stable(tag_i)
                                   && $stable(has_fflags_i) && $stable(fflags_i)))
        else $error("Response changed while stalled");

    a_reset_idle: assert property (@(posedge clk) !arst_n_i |-> !valid_i)
        else $error("valid_o high during reset");

    a_flags_gated: assert property (@(posedge clk) disable iff (!arst_n_i)
        (valid_i && !has_fflags_i) |-> (fflags_i == '0))
        else $error("fflags set without has_fflags");

endmodule

bind fpu_ncp fpu_ncp_chk #(.NUM_LANES(NUM_LANES), .TAG_WIDTH(TAG_WIDTH)) u_chk (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .valid_i      (valid_o),
    .ready_i      (ready_i),
    .result_i     (result_o),
    .has_fflags_i (has_fflags_o),
    .fflags_i     (fflags_o),
    .tag_i        (tag_o)
);

`default_nettype wire

// File: src/fpu_ncp.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ncp #(
    parameter int NUM_LANES = fpu_pkg::LANES_DEF,
    parameter int TAG_WIDTH = fpu_pkg::TAG_W_DEF
) (
    input  wire                                      clk,
    input  wire                                      arst_n_i,
    input  wire                                      valid_i,
    output wire                                      ready_o,
    input  wire [NUM_LANES-1:0]                      mask_i,
    input  wire [TAG_WIDTH-1:0]                      tag_i,
    input  var fpu_pkg::fpu_op_e                     op_type_i,
    input  wire [fpu_pkg::FRM_W-1:0]                 frm_i,
    input  wire [NUM_LANES-1:0][fpu_pkg::XLEN-1:0]   dataa_i,
    input  wire [NUM_LANES-1:0][fpu_pkg::XLEN-1:0]   datab_i,
    output wire [NUM_LANES-1:0][fpu_pkg::XLEN-1:0]   result_o,
    output wire                                      has_fflags_o,
    output fpu_pkg::fflags_t                         fflags_o,
    output wire [TAG_WIDTH-1:0]                      tag_o,
    output wire                                      valid_o,
    input  wire                                      ready_i
);
    import fpu_pkg::*;

    typedef struct packed {
        logic [NUM_LANES-1:0]            mask;
        logic [TAG_WIDTH-1:0]            tag;
        req_ctrl_t                       ctrl;
        logic [NUM_LANES-1:0][XLEN-1:0]  a;
        logic [NUM_LANES-1:0][XLEN-1:0]  b;
    } req_t;

    typedef struct packed {
        logic [NUM_LANES-1:0][XLEN-1:0]  result;
        logic                            has_fflags;
        fflags_t                         fflags;
        logic [TAG_WIDTH-1:0]            tag;
    } rsp_t;

    req_t                 req_in, req;
    rsp_t                 rsp_in, rsp;
    logic                 req_valid, rsp_ready;
    logic [NUM_LANES-1:0] lane_nv;

    fpu_lane_if lane_if ();

    assign req_in = '{mask: mask_i, tag: tag_i, ctrl: '{op_type: op_type_i, frm: frm_i},
                      a: dataa_i, b: datab_i};

    fpu_elastic_buf #(.payload_t(req_t)) req_buf (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .data_i   (req_in),
        .valid_o  (req_valid),
        .ready_i  (rsp_ready),
        .data_o   (req)
    );

    fpu_ncp_ctrl #(.NUM_LANES(NUM_LANES)) u_ctrl (
        .op_type_i    (req.ctrl.op_type),
        .frm_i        (req.ctrl.frm),
        .mask_i       (req.mask),
        .lane_nv_i    (lane_nv),
        .lane         (lane_if.ctrl),
        .has_fflags_o (rsp_in.has_fflags),
        .fflags_o     (rsp_in.fflags)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        fpu_ncp_lane u_lane (
            .lane     (lane_if.lane),
            .active_i (req.mask[i]),
            .a_i      (req.a[i]),
            .b_i      (req.b[i]),
            .res_o    (rsp_in.result[i]),
            .nv_o     (lane_nv[i])
        );
    end

    assign rsp_in.tag = req.tag;  // Tag rides along unchanged

    fpu_elastic_buf #(.payload_t(rsp_t)) rsp_buf (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (req_valid),
        .ready_o  (rsp_ready),
        .data_i   (rsp_in),
        .valid_o  (valid_o),
        .ready_i  (ready_i),
        .data_o   (rsp)
    );

    assign result_o     = rsp.result;
    assign has_fflags_o = rsp.has_fflags;
    assign fflags_o     = rsp.fflags;
    assign tag_o        = rsp.tag;

endmodule

`default_nettype wire

// File: src/fpu_ncp_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ncp_ctrl #(
    parameter int NUM_LANES = 4
) (
    input  var fpu_pkg::fpu_op_e          op_type_i,
    input  wire [fpu_pkg::FRM_W-1:0]      frm_i,
    input  wire [NUM_LANES-1:0]           mask_i,
    input  wire [NUM_LANES-1:0]           lane_nv_i,
    fpu_lane_if.ctrl                      lane,
    output logic                          has_fflags_o,
    output fpu_pkg::fflags_t              fflags_o
);
    import fpu_pkg::*;

    ncp_sel_e   sel_d;
    logic [1:0] sub_d;
    logic       chk_nan_d;

    always_comb begin
        sel_d        = SEL_SGNJ;
        sub_d        = frm_i[1:0];
        chk_nan_d    = 1'b0;
        has_fflags_o = 1'b0;
        if (op_type_i == FPU_CMP) begin
            sel_d        = SEL_CMP;
            has_fflags_o = 1'b1;
            // frm 3..7 map to the null compare
            sub_d        = (frm_i > 3'd2) ? 2'd3 : frm_i[1:0];
            chk_nan_d    = (frm_i == 3'd0) || (frm_i == 3'd1);  // FLE, FLT
        end else begin
            case (frm_i)
                3'd0, 3'd1, 3'd2: sel_d = SEL_SGNJ;
                3'd3:             sel_d = SEL_CLASS;
                3'd4, 3'd5:       sel_d = SEL_MOVE;
                default: begin
                    sel_d        = SEL_MINMAX;
                    sub_d        = {1'b0, frm_i[0]};  // 0 min, 1 max
                    has_fflags_o = 1'b1;
                end
            endcase
        end
    end

    assign lane.sel     = sel_d;
    assign lane.sub     = sub_d;
    assign lane.chk_nan = chk_nan_d;

    // Only nv can be raised by these operations
    always_comb begin
        fflags_o    = '0;
        fflags_o.nv = has_fflags_o & (|(lane_nv_i & mask_i));
    end

endmodule

`default_nettype wire

// File: src/fpu_ncp_lane.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ncp_lane (
    fpu_lane_if.lane                    lane,
    input  wire                         active_i,
    input  wire [fpu_pkg::XLEN-1:0]     a_i,
    input  wire [fpu_pkg::XLEN-1:0]     b_i,
    output logic [fpu_pkg::XLEN-1:0]    res_o,
    output logic                        nv_o
);
    import fpu_pkg::*;

    logic            a_s, b_s;
    logic            a_exp_max, a_exp_zero, a_man_zero;
    logic            a_nan, b_nan, a_snan, b_snan;
    logic            both_zero, lt_tot, lt, eq;
    logic [9:0]      a_class;
    logic [XLEN-1:0] res;
    logic            nv;

    assign a_s        = a_i[31];
    assign b_s        = b_i[31];
    assign a_exp_max  = &a_i[30:23];
    assign a_exp_zero = ~|a_i[30:23];
    assign a_man_zero = ~|a_i[22:0];

    assign a_nan  = a_exp_max & ~a_man_zero;
    assign b_nan  = (&b_i[30:23]) & (|b_i[22:0]);
    assign a_snan = a_nan & ~a_i[22];  // Quiet bit clear
    assign b_snan = b_nan & ~b_i[22];

    // RISC-V class bits, one hot
    assign a_class = {
        a_nan & a_i[22],
        a_snan,
        ~a_s & a_exp_max & a_man_zero,
        ~a_s & ~a_exp_max & ~a_exp_zero,
        ~a_s & a_exp_zero & ~a_man_zero,
        ~a_s & a_exp_zero & a_man_zero,
        a_s & a_exp_zero & a_man_zero,
        a_s & a_exp_zero & ~a_man_zero,
        a_s & ~a_exp_max & ~a_exp_zero,
        a_s & a_exp_max & a_man_zero
    };

    // Total order puts -0 below +0, IEEE order treats them equal
    assign both_zero = ~|{a_i[30:0], b_i[30:0]};
    assign lt_tot    = (a_s != b_s) ? a_s :
                       (a_s ? (a_i[30:0] > b_i[30:0]) : (a_i[30:0] < b_i[30:0]));
    assign lt        = lt_tot & ~both_zero;
    assign eq        = (a_i == b_i) | both_zero;

    always_comb begin
        res = a_i;
        nv  = 1'b0;
        case (lane.sel)
            SEL_SGNJ: begin
                case (lane.sub)
                    2'd0:    res = {b_s, a_i[30:0]};
                    2'd1:    res = {~b_s, a_i[30:0]};
                    2'd2:    res = {a_s ^ b_s, a_i[30:0]};
                    default: res = a_i;
                endcase
            end
            SEL_CLASS: res = {22'd0, a_class};
            SEL_MOVE:  res = a_i;
            SEL_MINMAX: begin
                nv = a_snan | b_snan;
                if (a_nan & b_nan)
                    res = CANON_NAN;
                else if (a_nan)
                    res = b_i;  // Non-NaN operand wins
                else if (b_nan)
                    res = a_i;
                else
                    res = (lt_tot ^ lane.sub[0]) ? a_i : b_i;
            end
            SEL_CMP: begin
                res = '0;
                if (!(a_nan | b_nan)) begin
                    case (lane.sub)
                        2'd0:    res[0] = lt | eq;  // FLE
                        2'd1:    res[0] = lt;       // FLT
                        2'd2:    res[0] = eq;       // FEQ
                        default: res[0] = 1'b0;
                    endcase
                end
                if (lane.chk_nan)
                    nv = a_nan | b_nan;
                else
                    nv = (lane.sub == 2'd2) & (a_snan | b_snan);
            end
            default: res = a_i;
        endcase
    end

    assign res_o = active_i ? res : '0;
    assign nv_o  = active_i & nv;

endmodule

`default_nettype wire

// File: src/fpu_elastic_buf.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_elastic_buf #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      arst_n_i,
    input  wire      valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  wire      ready_i,
    output payload_t data_o
);

    logic     main_valid, ovf_valid;
    payload_t main_data, ovf_data;
    logic     main_free;  // Main slot empty or draining this cycle

    assign main_free = ~main_valid | ready_i;

    // Ready depends only on the overflow slot
    assign ready_o = ~ovf_valid;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            main_valid <= 1'b0;
            ovf_valid  <= 1'b0;
        end else if (main_free) begin
            main_valid <= ovf_valid | valid_i;
            ovf_valid  <= 1'b0;
        end else if (valid_i && !ovf_valid) begin
            ovf_valid <= 1'b1;  // Park the input while the output stalls
        end
    end

    always_ff @(posedge clk) begin
        if (main_free && (ovf_valid || valid_i))
            main_data <= ovf_valid ? ovf_data : data_i;  // Oldest entry first
        if (!main_free && valid_i && !ovf_valid)
            ovf_data <= data_i;
    end

    assign valid_o = main_valid;
    assign data_o  = main_data;

endmodule

`default_nettype wire

// File: src/fpu_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fpu_lane_if;
    import fpu_pkg::*;

    ncp_sel_e   sel;      // Operation for all lanes
    logic [1:0] sub;      // Sign-injection kind, min/max choice or compare kind
    logic       chk_nan;  // Quiet NaN also raises nv

    modport ctrl (
        output sel,
        output sub,
        output chk_nan
    );

    modport lane (
        input sel,
        input sub,
        input chk_nan
    );

endinterface

`default_nettype wire

// File: src/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

    localparam int XLEN      = 32;
    localparam int FRM_W     = 3;
    localparam int TAG_W_DEF = 6;  // Top-level defaults only
    localparam int LANES_DEF = 4;

    // Issue group in which frm picks the operation
    typedef enum logic {
        FPU_CMP  = 1'b0,
        FPU_MISC = 1'b1
    } fpu_op_e;

    // Decoded lane operation
    typedef enum logic [2:0] {
        SEL_SGNJ,
        SEL_CLASS,
        SEL_MOVE,
        SEL_MINMAX,
        SEL_CMP
    } ncp_sel_e;

    typedef struct packed {
        logic nv;  // Invalid operation
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    localparam logic [XLEN-1:0] CANON_NAN = 32'h7fc0_0000;

    // Lane-independent part of a request
    typedef struct packed {
        fpu_op_e          op_type;
        logic [FRM_W-1:0] frm;
    } req_ctrl_t;

endpackage

`default_nettype wire
